// File: common/spram_pkg.sv
//////////////////////////////////////////////////
// Scratch RAM subsystem shared definitions
// Bus widths, memory geometry and Wishbone codes
//////////////////////////////////////////////////

package spram_pkg;

  //////////////////////////////////////////////////
  // Memory geometry
  //////////////////////////////////////////////////

  // Data bus width in bits
  localparam int SPRAM_DW    = 32;
  // Total memory size in bytes
  localparam int SPRAM_BYTES = 1024;
  // Byte address width
  localparam int SPRAM_AW    = $clog2(SPRAM_BYTES);
  // One select bit per byte lane
  localparam int SPRAM_SELW  = SPRAM_DW / 8;
  // Byte offset bits inside a word
  localparam int SPRAM_OFFW  = $clog2(SPRAM_SELW);
  // Number of array words and their address width
  localparam int SPRAM_WORDS = SPRAM_BYTES / SPRAM_SELW;
  localparam int SPRAM_WAW   = $clog2(SPRAM_WORDS);

  //////////////////////////////////////////////////
  // Wishbone registered feedback codes
  //////////////////////////////////////////////////

  localparam int WB_CTI_W = 3;
  localparam int WB_BTE_W = 2;

  // Cycle type identifier
  typedef enum logic [WB_CTI_W-1:0] {
    WB_CTI_CLASSIC = 3'b000,
    WB_CTI_CONST   = 3'b001,
    WB_CTI_INCR    = 3'b010,
    WB_CTI_EOB     = 3'b111
  } wb_cti_e;

  // Burst type extension
  typedef enum logic [WB_BTE_W-1:0] {
    WB_BTE_LINEAR = 2'd0,
    WB_BTE_WRAP4  = 2'd1,
    WB_BTE_WRAP8  = 2'd2,
    WB_BTE_WRAP16 = 2'd3
  } wb_bte_e;

  // Arbiter ownership state
  typedef enum logic [1:0] {
    ARB_IDLE = 2'd0,
    ARB_OWN0 = 2'd1,
    ARB_OWN1 = 2'd2
  } arb_state_e;

endpackage

// File: common/wb_bus_if.sv
//////////////////////////////////////////////////
// Wishbone bus between arbiter and RAM slave
//////////////////////////////////////////////////

`timescale 1ns/1ns

interface wb_bus_if import spram_pkg::*; ();

  // Request side, driven by the bus owner
  logic [SPRAM_AW-1:0]   adr;
  logic [SPRAM_DW-1:0]   dat_w;
  logic [SPRAM_SELW-1:0] sel;
  logic                  we;
  wb_cti_e               cti;
  wb_bte_e               bte;
  logic                  cyc;
  logic                  stb;

  // Response side, driven by the slave
  logic                  ack;
  logic [SPRAM_DW-1:0]   dat_r;

  // Arbiter view
  modport master (
    output adr,
    output dat_w,
    output sel,
    output we,
    output cti,
    output bte,
    output cyc,
    output stb,
    input  ack,
    input  dat_r
  );

  // RAM slave view
  modport slave (
    input  adr,
    input  dat_w,
    input  sel,
    input  we,
    input  cti,
    input  bte,
    input  cyc,
    input  stb,
    output ack,
    output dat_r
  );

endinterface

// File: filelist.f
common/spram_pkg.sv
common/wb_bus_if.sv
spram/spram_array.sv
spram/spram_wb_slave.sv
verilog/wb_rr_arbiter.sv
verilog/spram_subsystem_top.sv
test/tb_spram_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the scratch RAM testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_spram_subsystem \
  -f filelist.f -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat build.log; cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0

// File: spram/spram_array.sv
//////////////////////////////////////////////////
// Byte writable word array, registered read
//////////////////////////////////////////////////

`timescale 1ns/1ns

module spram_array import spram_pkg::*; (
  input  logic                  biu_clk_i,
  input  logic [SPRAM_SELW-1:0] we_i,
  input  logic [SPRAM_WAW-1:0]  waddr_i,
  input  logic [SPRAM_WAW-1:0]  raddr_i,
  input  logic [SPRAM_DW-1:0]   din_i,
  output logic [SPRAM_DW-1:0]   dout_o
);

  // Storage words
  logic [SPRAM_DW-1:0] mem [SPRAM_WORDS];

  // Each byte lane has its own write strobe
  always_ff @(posedge biu_clk_i) begin
    for (int lane = 0; lane < SPRAM_SELW; lane++) begin
      if (we_i[lane]) begin
        mem[waddr_i][lane*8 +: 8] <= din_i[lane*8 +: 8];
      end
    end
  end

  // Read port samples every edge, old data on same address write
  always_ff @(posedge biu_clk_i) begin
    dout_o <= mem[raddr_i];
  end

endmodule

// File: spram/spram_wb_slave.sv
//////////////////////////////////////////////////
// Wishbone RAM slave with registered feedback
// Acks classic and burst cycles, steps burst addresses
//////////////////////////////////////////////////

`timescale 1ns/1ns

module spram_wb_slave import spram_pkg::*; (
  input logic      biu_clk_i,
  input logic      biu_rst_i,
  wb_bus_if.slave  bus_i
);

  //////////////////////////////////////////////////
  // Burst address stepping
  //////////////////////////////////////////////////

  // Next word address for the beat after this one
  function automatic logic [SPRAM_WAW-1:0] wb_next_word(
    input logic [SPRAM_WAW-1:0] cur,
    input wb_cti_e              cti,
    input wb_bte_e              bte
  );
    logic [SPRAM_WAW-1:0] nxt;
    nxt = cur;
    // Constant bursts and single beats keep the address
    if (cti == WB_CTI_INCR) begin
      case (bte)
        WB_BTE_LINEAR: nxt = cur + 1'b1;
        // Wrap bursts only count in the low word bits
        WB_BTE_WRAP4:  nxt[1:0] = cur[1:0] + 2'd1;
        WB_BTE_WRAP8:  nxt[2:0] = cur[2:0] + 3'd1;
        WB_BTE_WRAP16: nxt[3:0] = cur[3:0] + 4'd1;
        default:       nxt = cur;
      endcase
    end
    return nxt;
  endfunction

  //////////////////////////////////////////////////
  // Cycle tracking
  //////////////////////////////////////////////////

  logic                  valid;
  logic                  valid_r;
  logic                  beat_last;
  logic                  is_last_r;
  logic                  new_cycle;
  logic                  ack_r;
  logic [SPRAM_WAW-1:0]  adr_r;
  logic [SPRAM_WAW-1:0]  next_adr;
  logic [SPRAM_WAW-1:0]  adr;
  logic [SPRAM_SELW-1:0] ram_we;

  // Request present on the bus
  assign valid = bus_i.cyc & bus_i.stb;

  // Classic beats and end of burst close the transfer
  assign beat_last = (bus_i.cti == WB_CTI_CLASSIC) || (bus_i.cti == WB_CTI_EOB);

  // Rising request, or the previous beat closed its transfer
  assign new_cycle = (valid & ~valid_r) | is_last_r;

  assign next_adr = wb_next_word(adr_r, bus_i.cti, bus_i.bte);

  // Take the bus word address at transfer start, else keep stepping
  assign adr = new_cycle ? bus_i.adr[SPRAM_AW-1:SPRAM_OFFW] : next_adr;

  always_ff @(posedge biu_clk_i) begin
    if (biu_rst_i) begin
      valid_r   <= 1'b0;
      is_last_r <= 1'b0;
      ack_r     <= 1'b0;
      adr_r     <= '0;
    end else begin
      valid_r   <= valid;
      is_last_r <= beat_last;
      adr_r     <= adr;
      // Burst beats keep ack high, classic beats toggle it
      ack_r     <= valid & (~beat_last | ~ack_r);
    end
  end

  assign bus_i.ack = ack_r;

  //////////////////////////////////////////////////
  // RAM access
  //////////////////////////////////////////////////

  // Write lands at the registered address during the acked beat
  assign ram_we = {SPRAM_SELW{bus_i.we & valid & ack_r}} & bus_i.sel;

  spram_array spram_array_inst (
    .biu_clk_i (biu_clk_i),
    .we_i      (ram_we),
    .waddr_i   (adr_r),
    .raddr_i   (adr),
    .din_i     (bus_i.dat_w),
    .dout_o    (bus_i.dat_r)
  );

  //////////////////////////////////////////////////
  // Protocol checks
  //////////////////////////////////////////////////

  // Every ack answers a request seen one edge earlier
  ack_follows_req_a : assert property (
    @(posedge biu_clk_i) disable iff (biu_rst_i)
    bus_i.ack |-> $past(bus_i.cyc & bus_i.stb)
  );

  // Only the four defined cycle types reach the slave
  cti_legal_a : assert property (
    @(posedge biu_clk_i) disable iff (biu_rst_i)
    (bus_i.cyc & bus_i.stb) |->
      (bus_i.cti inside {WB_CTI_CLASSIC, WB_CTI_CONST, WB_CTI_INCR, WB_CTI_EOB})
  );

endmodule

// File: test/tb_spram_subsystem.sv
//////////////////////////////////////////////////
// Testbench for the shared scratch RAM subsystem
// Random Wishbone traffic from two masters vs a byte model
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_spram_subsystem import spram_pkg::*; ();

  logic                  biu_clk;
  logic                  biu_rst;
  logic [SPRAM_AW-1:0]   m0_adr, m1_adr;
  logic [SPRAM_DW-1:0]   m0_dat_w, m1_dat_w;
  logic [SPRAM_SELW-1:0] m0_sel, m1_sel;
  logic                  m0_we, m1_we;
  logic [WB_CTI_W-1:0]   m0_cti, m1_cti;
  logic [WB_BTE_W-1:0]   m0_bte, m1_bte;
  logic                  m0_cyc, m1_cyc;
  logic                  m0_stb, m1_stb;
  logic                  m0_ack, m1_ack;
  logic [SPRAM_DW-1:0]   m0_dat_r, m1_dat_r;

  // Reference memory with one entry per byte
  logic [7:0]  model_mem [SPRAM_BYTES];
  // Per master beat data for writes and reads
  logic [31:0] wbuf [2][16];
  logic [31:0] rbuf [2][16];
  int          ack_cyc [2];
  logic [3:0]  sel_m [2];
  logic        last_served;
  logic [15:0] lfsr;
  int          errors;
  int          cycle_cnt;

  spram_subsystem_top spram_subsystem_top_inst (
    .biu_clk_i (biu_clk),
    .biu_rst_i (biu_rst),
    .m0_adr_i  (m0_adr),
    .m0_dat_i  (m0_dat_w),
    .m0_sel_i  (m0_sel),
    .m0_we_i   (m0_we),
    .m0_cti_i  (m0_cti),
    .m0_bte_i  (m0_bte),
    .m0_cyc_i  (m0_cyc),
    .m0_stb_i  (m0_stb),
    .m0_ack_o  (m0_ack),
    .m0_dat_o  (m0_dat_r),
    .m1_adr_i  (m1_adr),
    .m1_dat_i  (m1_dat_w),
    .m1_sel_i  (m1_sel),
    .m1_we_i   (m1_we),
    .m1_cti_i  (m1_cti),
    .m1_bte_i  (m1_bte),
    .m1_cyc_i  (m1_cyc),
    .m1_stb_i  (m1_stb),
    .m1_ack_o  (m1_ack),
    .m1_dat_o  (m1_dat_r)
  );

  // 20 ns clock period
  always #10 biu_clk = ~biu_clk;

  always @(posedge biu_clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // Acks must never reach both masters at once
  always @(negedge biu_clk) begin
    if (!biu_rst && m0_ack && m1_ack) begin
      errors++;
      $display("Both masters received an ack in the same cycle at cycle %0d", cycle_cnt);
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Fibonacci LFSR x^16+x^14+x^13+x^11 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  // Word after w in a burst where wrap bursts count inside their block
  function automatic logic [7:0] burst_next(input logic [7:0] w, input logic [2:0] cti,
                                            input logic [1:0] bte);
    logic [7:0] mask;
    case (bte)
      WB_BTE_WRAP4:  mask = 8'h03;
      WB_BTE_WRAP8:  mask = 8'h07;
      WB_BTE_WRAP16: mask = 8'h0F;
      default:       mask = 8'hFF;
    endcase
    if (cti != WB_CTI_INCR) begin
      return w;
    end
    return (w & ~mask) | ((w + 8'd1) & mask);
  endfunction

  // Cycle type of beat k out of n
  function automatic logic [2:0] beat_cti(input int k, input int n, input logic [2:0] bcti);
    if (n == 1) begin
      return WB_CTI_CLASSIC;
    end
    return (k == n - 1) ? WB_CTI_EOB : bcti;
  endfunction

  function automatic logic [31:0] model_word(input logic [7:0] wa);
    return {model_mem[{wa, 2'd3}], model_mem[{wa, 2'd2}],
            model_mem[{wa, 2'd1}], model_mem[{wa, 2'd0}]};
  endfunction

  function automatic logic ack_of(input logic m);
    return m ? m1_ack : m0_ack;
  endfunction

  function automatic logic [31:0] dat_of(input logic m);
    return m ? m1_dat_r : m0_dat_r;
  endfunction

  task automatic drive_req(input logic m, input logic [9:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel, input logic we, input logic [2:0] cti,
                           input logic [1:0] bte, input logic req);
    if (m) begin
      m1_adr   = adr;
      m1_dat_w = dat;
      m1_sel   = sel;
      m1_we    = we;
      m1_cti   = cti;
      m1_bte   = bte;
      m1_cyc   = req;
      m1_stb   = req;
    end else begin
      m0_adr   = adr;
      m0_dat_w = dat;
      m0_sel   = sel;
      m0_we    = we;
      m0_cti   = cti;
      m0_bte   = bte;
      m0_cyc   = req;
      m0_stb   = req;
    end
  endtask

  // One Wishbone cycle of nbeats beats started 2 ns after a rising edge
  task automatic bus_xfer(input logic m, input logic we, input logic [7:0] wa0, input int nbeats,
                          input logic [2:0] bcti, input logic [1:0] bte, input logic [3:0] sel);
    logic [7:0] wa;
    logic [2:0] cti;
    int         beat;
    int         wait_cnt;
    wa   = wa0;
    beat = 0;
    while (beat < nbeats) begin
      cti = beat_cti(beat, nbeats, bcti);
      drive_req(m, {wa, 2'b00}, wbuf[m][beat[3:0]], sel, we, cti, bte, 1'b1);
      // Ack seen mid cycle means the beat ends at the next edge
      wait_cnt = 0;
      @(negedge biu_clk);
      while (!ack_of(m) && wait_cnt < 100) begin
        wait_cnt++;
        @(negedge biu_clk);
      end
      if (!ack_of(m)) begin
        errors++;
        $display("Timeout waiting for ack on master %0d", m);
        break;
      end
      if (beat == 0) begin
        ack_cyc[m] = cycle_cnt;
      end
      rbuf[m][beat[3:0]] = dat_of(m);
      @(posedge biu_clk);
      #2;
      wa = burst_next(wa, cti, bte);
      beat++;
    end
    drive_req(m, 10'd0, 32'd0, 4'd0, 1'b0, WB_CTI_CLASSIC, WB_BTE_LINEAR, 1'b0);
    last_served = m;
    // One idle cycle lets the arbiter return to idle
    @(posedge biu_clk);
    #2;
  endtask

  // Apply a completed write cycle to the reference memory
  task automatic model_apply(input logic m, input logic [7:0] wa0, input int nbeats,
                             input logic [2:0] bcti, input logic [1:0] bte, input logic [3:0] sel);
    logic [7:0] wa;
    wa = wa0;
    for (int k = 0; k < nbeats; k++) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (sel[lane]) begin
          model_mem[{wa, lane[1:0]}] = wbuf[m][k[3:0]][lane*8 +: 8];
        end
      end
      wa = burst_next(wa, beat_cti(k, nbeats, bcti), bte);
    end
  endtask

  task automatic read_check(input logic m, input logic [7:0] wa, input string name);
    bus_xfer(m, 1'b0, wa, 1, WB_CTI_CLASSIC, WB_BTE_LINEAR, 4'hF);
    check_val(name, model_word(wa), rbuf[m][0]);
  endtask

  task automatic fill_random(input logic m, input int n);
    for (int k = 0; k < n; k++) begin
      wbuf[m][k[3:0]] = rand_bits(32);
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] rnd;
    logic [7:0]  wa;
    logic [7:0]  ra;
    logic        m;
    logic        exp_first;
    logic        act_first;
    logic [1:0]  bte;
    int          len;
    biu_clk     = 1'b0;
    biu_rst     = 1'b1;
    errors      = 0;
    cycle_cnt   = 0;
    lfsr        = 16'd40;
    last_served = 1'b1;
    drive_req(1'b0, 10'd0, 32'd0, 4'd0, 1'b0, WB_CTI_CLASSIC, WB_BTE_LINEAR, 1'b0);
    drive_req(1'b1, 10'd0, 32'd0, 4'd0, 1'b0, WB_CTI_CLASSIC, WB_BTE_LINEAR, 1'b0);

    // Reset state
    repeat (8) begin
      @(negedge biu_clk);
      check_val("reset ack m0", 32'd0, {31'd0, m0_ack});
      check_val("reset ack m1", 32'd0, {31'd0, m1_ack});
    end
    @(posedge biu_clk);
    #2;
    biu_rst = 1'b0;
    @(negedge biu_clk);
    check_val("post reset ack m0", 32'd0, {31'd0, m0_ack});
    check_val("post reset ack m1", 32'd0, {31'd0, m1_ack});
    @(posedge biu_clk);
    #2;

    // Known contents everywhere from a pattern built on the word address
    for (int b = 0; b < 16; b++) begin
      for (int k = 0; k < 16; k++) begin
        wa = 8'(b * 16 + k);
        wbuf[0][k] = {~wa, wa, wa ^ 8'h5A, wa + 8'h3C};
      end
      wa = 8'(b * 16);
      bus_xfer(1'b0, 1'b1, wa, 16, WB_CTI_INCR, WB_BTE_LINEAR, 4'hF);
      model_apply(1'b0, wa, 16, WB_CTI_INCR, WB_BTE_LINEAR, 4'hF);
    end

    // Classic accesses with byte selects
    for (int i = 0; i < 24; i++) begin
      rnd = rand_bits(14);
      m   = rnd[13];
      wa  = rnd[12:5];
      sel_m[m] = rnd[3:0];
      fill_random(m, 1);
      bus_xfer(m, 1'b1, wa, 1, WB_CTI_CLASSIC, WB_BTE_LINEAR, sel_m[m]);
      model_apply(m, wa, 1, WB_CTI_CLASSIC, WB_BTE_LINEAR, sel_m[m]);
      read_check(rnd[4], wa, "classic read");
    end

    // Linear bursts written then read back as bursts
    for (int i = 0; i < 8; i++) begin
      rnd = rand_bits(12);
      m   = rnd[11];
      wa  = rnd[10:3];
      len = 2 + (int'(rnd[2:0]) % 7);
      fill_random(m, len);
      bus_xfer(m, 1'b1, wa, len, WB_CTI_INCR, WB_BTE_LINEAR, 4'hF);
      model_apply(m, wa, len, WB_CTI_INCR, WB_BTE_LINEAR, 4'hF);
      bus_xfer(~m, 1'b0, wa, len, WB_CTI_INCR, WB_BTE_LINEAR, 4'hF);
      ra = wa;
      for (int k = 0; k < len; k++) begin
        check_val("linear burst read", model_word(ra), rbuf[~m][k]);
        ra = ra + 8'd1;
      end
    end

    // Wrap bursts from random offsets checked by classic reads
    for (int i = 0; i < 6; i++) begin
      rnd = rand_bits(9);
      m   = rnd[8];
      wa  = rnd[7:0];
      bte = 2'(1 + (i % 3));
      len = 2 << bte;
      fill_random(m, len);
      bus_xfer(m, 1'b1, wa, len, WB_CTI_INCR, bte, 4'hF);
      model_apply(m, wa, len, WB_CTI_INCR, bte, 4'hF);
      ra = wa;
      for (int k = 0; k < len; k++) begin
        read_check(m, ra, "wrap burst word");
        ra = burst_next(ra, WB_CTI_INCR, bte);
      end
    end

    // Constant bursts where the last beat must win
    for (int i = 0; i < 4; i++) begin
      rnd = rand_bits(11);
      m   = rnd[10];
      wa  = rnd[9:2];
      len = 2 + int'(rnd[1:0]);
      fill_random(m, len);
      bus_xfer(m, 1'b1, wa, len, WB_CTI_CONST, WB_BTE_LINEAR, 4'hF);
      model_apply(m, wa, len, WB_CTI_CONST, WB_BTE_LINEAR, 4'hF);
      read_check(~m, wa, "constant burst word");
    end

    // Contention on overlapping words where a tie goes to the master not served last
    for (int i = 0; i < 6; i++) begin
      rnd = rand_bits(16);
      wa  = rnd[15:8];
      sel_m[0] = rnd[7:4];
      sel_m[1] = rnd[3:0];
      fill_random(1'b0, 2);
      fill_random(1'b1, 2);
      exp_first = ~last_served;
      fork
        bus_xfer(1'b0, 1'b1, wa, 2, WB_CTI_INCR, WB_BTE_LINEAR, sel_m[0]);
        bus_xfer(1'b1, 1'b1, wa, 2, WB_CTI_INCR, WB_BTE_LINEAR, sel_m[1]);
      join
      act_first = (ack_cyc[0] < ack_cyc[1]) ? 1'b0 : 1'b1;
      check_val("contention winner", {31'd0, exp_first}, {31'd0, act_first});
      model_apply(act_first, wa, 2, WB_CTI_INCR, WB_BTE_LINEAR, sel_m[act_first]);
      model_apply(~act_first, wa, 2, WB_CTI_INCR, WB_BTE_LINEAR, sel_m[~act_first]);
      // Winner reads last so the next tie should go to the other master
      read_check(~act_first, wa, "contention word 0");
      read_check(act_first, wa + 8'd1, "contention word 1");
    end

    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: verilog/spram_subsystem_top.sv
//////////////////////////////////////////////////
// Shared scratch RAM subsystem top
// Two Wishbone masters share one RAM slave
//////////////////////////////////////////////////

`timescale 1ns/1ns

module spram_subsystem_top import spram_pkg::*; (
  input  logic                  biu_clk_i,
  input  logic                  biu_rst_i,

  // Master 0 port
  input  logic [SPRAM_AW-1:0]   m0_adr_i,
  input  logic [SPRAM_DW-1:0]   m0_dat_i,
  input  logic [SPRAM_SELW-1:0] m0_sel_i,
  input  logic                  m0_we_i,
  input  logic [WB_CTI_W-1:0]   m0_cti_i,
  input  logic [WB_BTE_W-1:0]   m0_bte_i,
  input  logic                  m0_cyc_i,
  input  logic                  m0_stb_i,
  output logic                  m0_ack_o,
  output logic [SPRAM_DW-1:0]   m0_dat_o,

  // Master 1 port
  input  logic [SPRAM_AW-1:0]   m1_adr_i,
  input  logic [SPRAM_DW-1:0]   m1_dat_i,
  input  logic [SPRAM_SELW-1:0] m1_sel_i,
  input  logic                  m1_we_i,
  input  logic [WB_CTI_W-1:0]   m1_cti_i,
  input  logic [WB_BTE_W-1:0]   m1_bte_i,
  input  logic                  m1_cyc_i,
  input  logic                  m1_stb_i,
  output logic                  m1_ack_o,
  output logic [SPRAM_DW-1:0]   m1_dat_o
);

  // Shared bus from arbiter to RAM slave
  wb_bus_if wb_bus ();

  // Picks one master per cycle
  wb_rr_arbiter wb_rr_arbiter_inst (
    .biu_clk_i (biu_clk_i),
    .biu_rst_i (biu_rst_i),
    .m0_adr_i  (m0_adr_i),
    .m0_dat_i  (m0_dat_i),
    .m0_sel_i  (m0_sel_i),
    .m0_we_i   (m0_we_i),
    .m0_cti_i  (m0_cti_i),
    .m0_bte_i  (m0_bte_i),
    .m0_cyc_i  (m0_cyc_i),
    .m0_stb_i  (m0_stb_i),
    .m1_adr_i  (m1_adr_i),
    .m1_dat_i  (m1_dat_i),
    .m1_sel_i  (m1_sel_i),
    .m1_we_i   (m1_we_i),
    .m1_cti_i  (m1_cti_i),
    .m1_bte_i  (m1_bte_i),
    .m1_cyc_i  (m1_cyc_i),
    .m1_stb_i  (m1_stb_i),
    .m0_ack_o  (m0_ack_o),
    .m0_dat_o  (m0_dat_o),
    .m1_ack_o  (m1_ack_o),
    .m1_dat_o  (m1_dat_o),
    .bus_o     (wb_bus.master)
  );

  // Scratch RAM behind the shared bus
  spram_wb_slave spram_wb_slave_inst (
    .biu_clk_i (biu_clk_i),
    .biu_rst_i (biu_rst_i),
    .bus_i     (wb_bus.slave)
  );

endmodule

// File: verilog/wb_rr_arbiter.sv
//////////////////////////////////////////////////
// Two master round robin Wishbone arbiter
// Grants the shared bus for a whole cycle
//////////////////////////////////////////////////

`timescale 1ns/1ns

module wb_rr_arbiter import spram_pkg::*; (
  input  logic                  biu_clk_i,
  input  logic                  biu_rst_i,

  // Master 0 request
  input  logic [SPRAM_AW-1:0]   m0_adr_i,
  input  logic [SPRAM_DW-1:0]   m0_dat_i,
  input  logic [SPRAM_SELW-1:0] m0_sel_i,
  input  logic                  m0_we_i,
  input  logic [WB_CTI_W-1:0]   m0_cti_i,
  input  logic [WB_BTE_W-1:0]   m0_bte_i,
  input  logic                  m0_cyc_i,
  input  logic                  m0_stb_i,

  // Master 1 request
  input  logic [SPRAM_AW-1:0]   m1_adr_i,
  input  logic [SPRAM_DW-1:0]   m1_dat_i,
  input  logic [SPRAM_SELW-1:0] m1_sel_i,
  input  logic                  m1_we_i,
  input  logic [WB_CTI_W-1:0]   m1_cti_i,
  input  logic [WB_BTE_W-1:0]   m1_bte_i,
  input  logic                  m1_cyc_i,
  input  logic                  m1_stb_i,

  // Responses
  output logic                  m0_ack_o,
  output logic [SPRAM_DW-1:0]   m0_dat_o,
  output logic                  m1_ack_o,
  output logic [SPRAM_DW-1:0]   m1_dat_o,

  wb_bus_if.master              bus_o
);

  //////////////////////////////////////////////////
  // Ownership FSM
  //////////////////////////////////////////////////

  arb_state_e state;
  arb_state_e state_nxt;
  // Set when master 1 had the bus last
  logic       last_m1;
  logic       own0;
  logic       own1;
  logic       owner_cyc;

  always_comb begin
    state_nxt = state;
    case (state)
      ARB_IDLE: begin
        // On a tie the master not served last wins
        if (m0_cyc_i && (!m1_cyc_i || last_m1)) begin
          state_nxt = ARB_OWN0;
        end else if (m1_cyc_i) begin
          state_nxt = ARB_OWN1;
        end
      end
      // Owner keeps the bus until its cyc drops
      ARB_OWN0: if (!m0_cyc_i) state_nxt = ARB_IDLE;
      ARB_OWN1: if (!m1_cyc_i) state_nxt = ARB_IDLE;
      default:  state_nxt = ARB_IDLE;
    endcase
  end

  always_ff @(posedge biu_clk_i) begin
    if (biu_rst_i) begin
      state   <= ARB_IDLE;
      last_m1 <= 1'b1;
    end else begin
      state <= state_nxt;
      if (state_nxt == ARB_OWN0) begin
        last_m1 <= 1'b0;
      end else if (state_nxt == ARB_OWN1) begin
        last_m1 <= 1'b1;
      end
    end
  end

  assign own0 = (state == ARB_OWN0);
  assign own1 = (state == ARB_OWN1);

  //////////////////////////////////////////////////
  // Request mux toward the slave
  //////////////////////////////////////////////////

  // Master 0 fields sit on the bus when idle, cyc and stb stay low
  assign owner_cyc   = (own0 & m0_cyc_i) | (own1 & m1_cyc_i);
  assign bus_o.cyc   = owner_cyc;
  assign bus_o.stb   = (own0 & m0_stb_i) | (own1 & m1_stb_i);
  assign bus_o.adr   = own1 ? m1_adr_i : m0_adr_i;
  assign bus_o.dat_w = own1 ? m1_dat_i : m0_dat_i;
  assign bus_o.sel   = own1 ? m1_sel_i : m0_sel_i;
  assign bus_o.we    = own1 ? m1_we_i  : m0_we_i;
  assign bus_o.cti   = wb_cti_e'(own1 ? m1_cti_i : m0_cti_i);
  assign bus_o.bte   = wb_bte_e'(own1 ? m1_bte_i : m0_bte_i);

  // Response goes back to the owner only
  assign m0_ack_o = own0 & bus_o.ack;
  assign m1_ack_o = own1 & bus_o.ack;
  assign m0_dat_o = own0 ? bus_o.dat_r : '0;
  assign m1_dat_o = own1 ? bus_o.dat_r : '0;

  //////////////////////////////////////////////////
  // Arbitration checks
  //////////////////////////////////////////////////

  // Never ack both masters in one cycle
  one_ack_a : assert property (
    @(posedge biu_clk_i) disable iff (biu_rst_i)
    !(m0_ack_o && m1_ack_o)
  );

  // Grant is held while the owner keeps cyc up
  grant_held_a : assert property (
    @(posedge biu_clk_i) disable iff (biu_rst_i)
    (state != ARB_IDLE) && owner_cyc |=> (state == $past(state))
  );

endmodule
